/* hw/branch_config.svh */
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// Register bus
// Byte address, word index sits in bits 3:2
`define BR_WB_ADDR_WIDTH 4

// Statistics counters
// Wrap on overflow, zero-extended on read
`define BR_COUNT_WIDTH 32

`endif

/* hw/branch_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_decode (
    input  logic [31:0]        instr,
    input  logic               issue_valid,
    output logic               accept,
    output logic               unit_needed,
    output logic               uses_rs1,
    output logic               uses_rs2,
    output branch_pkg::br_op_t br_op,
    output logic [31:0]        br_offset,
    output logic               br_is_call,
    output logic               br_is_return
);
    // Instruction fields
    branch_pkg::rv_opcode_t opcode;
    logic [2:0]  fn3;
    logic [4:0]  rs1_addr;
    logic [4:0]  rd_addr;

    // Sign-extended immediates, one per format
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_i;

    // Operation classes
    logic is_cond;
    logic is_jal;
    logic is_jalr;

    // Return-address stack support
    logic rs1_link;
    logic rd_link;

    assign opcode   = branch_pkg::rv_opcode_t'(instr[6:0]);
    assign fn3      = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rd_addr  = instr[11:7];

    ////////////////////
    // Operation select

    always_comb begin
        br_op = branch_pkg::BR_NONE;
        case (opcode)
            branch_pkg::OPC_BRANCH: begin
                case (fn3)
                    3'b000:  br_op = branch_pkg::BR_BEQ;
                    3'b001:  br_op = branch_pkg::BR_BNE;
                    3'b100:  br_op = branch_pkg::BR_BLT;
                    3'b101:  br_op = branch_pkg::BR_BGE;
                    3'b110:  br_op = branch_pkg::BR_BLTU;
                    3'b111:  br_op = branch_pkg::BR_BGEU;
                    // 010 and 011 are not branches
                    default: br_op = branch_pkg::BR_NONE;
                endcase
            end
            branch_pkg::OPC_JAL: br_op = branch_pkg::BR_JAL;
            // JALR is only defined with fn3 of zero
            branch_pkg::OPC_JALR: begin
                if (fn3 == 3'b000) begin
                    br_op = branch_pkg::BR_JALR;
                end
            end
            default: br_op = branch_pkg::BR_NONE;
        endcase
    end

    assign is_jal  = (br_op == branch_pkg::BR_JAL);
    assign is_jalr = (br_op == branch_pkg::BR_JALR);
    assign is_cond = br_op inside {branch_pkg::BR_BEQ, branch_pkg::BR_BNE,
                                   branch_pkg::BR_BLT, branch_pkg::BR_BGE,
                                   branch_pkg::BR_BLTU, branch_pkg::BR_BGEU};

    // Register use and acceptance
    assign unit_needed = (br_op != branch_pkg::BR_NONE);
    assign uses_rs1    = is_cond | is_jalr;
    assign uses_rs2    = is_cond;
    assign accept      = issue_valid & unit_needed;

    ////////////////////
    // Immediate offset

    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i = {{21{instr[31]}}, instr[30:20]};

    // Format follows the opcode, B layout otherwise
    always_comb begin
        case (opcode)
            branch_pkg::OPC_JAL:  br_offset = imm_j;
            branch_pkg::OPC_JALR: br_offset = imm_i;
            default:              br_offset = imm_b;
        endcase
    end

    ////////////////////
    // Call and return hints

    // Link registers are x1 and x5
    assign rs1_link = rs1_addr inside {5'd1, 5'd5};
    assign rd_link  = rd_addr inside {5'd1, 5'd5};

    // Pop unless rd links back to the same register
    assign br_is_return = is_jalr & rs1_link & (~rd_link | (rs1_addr != rd_addr));
    assign br_is_call   = (is_jal | is_jalr) & rd_link;

endmodule

`default_nettype wire

/* hw/branch_pkg.sv */
`default_nettype none

package branch_pkg;

    ////////////////////
    // Resolved operation

    // Kept at 4 bits so it fits a narrow pipeline field
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } br_op_t;

    ////////////////////
    // Major opcodes

    // Only the control-transfer group is recognised here
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } rv_opcode_t;

    ////////////////////
    // Register map

    // Word addresses of the Wishbone register block
    typedef enum logic [1:0] {
        REG_CTRL     = 2'd0,
        REG_RESOLVED = 2'd1,
        REG_FLUSHES  = 2'd2,
        REG_EXC_TVAL = 2'd3
    } br_reg_t;

endpackage

`default_nettype wire

/* hw/branch_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "branch_config.svh"

module branch_regs (
    input  logic                         clk,
    input  logic                         rst,
    // Wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`BR_WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    input  logic [3:0]                   wb_sel,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    // Resolver events
    input  logic                         result_valid,
    input  logic                         flush,
    input  logic                         exc_valid,
    input  logic [31:0]                  exc_tval,
    // Control out
    output logic                         misalign_en
);
    // Bus decode
    logic                       wb_req;
    logic                       ctrl_wr;
    branch_pkg::br_reg_t        reg_sel;
    logic [31:0]                rd_data;

    // Register state
    logic                       ctrl_misalign;
    logic [`BR_COUNT_WIDTH-1:0] resolved_count;
    logic [`BR_COUNT_WIDTH-1:0] flush_count;
    logic [31:0]                exc_tval_r;

    ////////////////////
    // Bus decode

    // New request only while no ack is out, so each cycle acks once
    assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
    assign reg_sel = branch_pkg::br_reg_t'(wb_adr[3:2]);
    // Only byte 0 of control is writable
    assign ctrl_wr = wb_req & wb_we & wb_sel[0] & (reg_sel == branch_pkg::REG_CTRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    ////////////////////
    // Registers

    // Check on by default
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_misalign <= 1'b1;
        end else if (ctrl_wr) begin
            ctrl_misalign <= wb_dat_w[0];
        end
    end

    assign misalign_en = ctrl_misalign;

    // Event counters, wrapping
    always_ff @(posedge clk) begin
        if (rst) begin
            resolved_count <= '0;
            flush_count    <= '0;
            exc_tval_r     <= 32'd0;
        end else begin
            if (result_valid) begin
                resolved_count <= resolved_count + 1'b1;
            end
            if (flush) begin
                flush_count <= flush_count + 1'b1;
            end
            // Last faulting target
            if (exc_valid) begin
                exc_tval_r <= exc_tval;
            end
        end
    end

    ////////////////////
    // Read path

    always_comb begin
        case (reg_sel)
            branch_pkg::REG_CTRL:     rd_data = {31'd0, ctrl_misalign};
            branch_pkg::REG_RESOLVED: rd_data = 32'(resolved_count);
            branch_pkg::REG_FLUSHES:  rd_data = 32'(flush_count);
            default:                  rd_data = exc_tval_r;
        endcase
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* hw/branch_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_resolve (
    input  logic               clk,
    input  logic               rst,
    // Decoded operands, valid with accept
    input  logic               accept,
    input  branch_pkg::br_op_t br_op,
    input  logic [31:0]        br_offset,
    input  logic               br_is_call,
    input  logic               br_is_return,
    // Issue-stage operands
    input  logic [31:0]        pc,
    input  logic [31:0]        rs1_val,
    input  logic [31:0]        rs2_val,
    input  logic [31:0]        pred_pc,
    // From control register
    input  logic               misalign_en,
    // Results, one cycle after accept
    output logic               result_valid,
    output logic               taken,
    output logic [31:0]        target,
    output logic               flush,
    output logic               is_call,
    output logic               is_return,
    output logic               exc_valid,
    output logic [31:0]        exc_tval
);
    // Comparator
    logic        br_use_signed;
    logic [32:0] rs1_ext;
    logic [32:0] rs2_ext;
    logic [33:0] cmp_diff;
    logic        cmp_eq;
    logic        cmp_lt;

    // Outcome in the issue cycle
    logic        branch_taken;
    logic        is_jalr;
    logic [31:0] jump_base;
    logic [31:0] jump_pc;
    logic [31:0] fall_pc;
    logic [31:0] new_pc;
    logic        mispredict;
    logic        misaligned;

    ////////////////////
    // Compare

    // Unsigned forms extend with zero, signed forms with bit 31
    assign br_use_signed = !(br_op inside {branch_pkg::BR_BLTU, branch_pkg::BR_BGEU});
    assign rs1_ext = {rs1_val[31] & br_use_signed, rs1_val};
    assign rs2_ext = {rs2_val[31] & br_use_signed, rs2_val};

    // Single subtractor gives both equal and less-than
    assign cmp_diff = {rs1_ext[32], rs1_ext} - {rs2_ext[32], rs2_ext};
    assign cmp_lt   = cmp_diff[33];
    assign cmp_eq   = (cmp_diff == 34'd0);

    always_comb begin
        case (br_op)
            branch_pkg::BR_BEQ:  branch_taken = cmp_eq;
            branch_pkg::BR_BNE:  branch_taken = !cmp_eq;
            branch_pkg::BR_BLT,
            branch_pkg::BR_BLTU: branch_taken = cmp_lt;
            branch_pkg::BR_BGE,
            branch_pkg::BR_BGEU: branch_taken = !cmp_lt;
            // Jumps always redirect
            branch_pkg::BR_JAL,
            branch_pkg::BR_JALR: branch_taken = 1'b1;
            default:             branch_taken = 1'b0;
        endcase
    end

    ////////////////////
    // Target

    assign is_jalr   = (br_op == branch_pkg::BR_JALR);
    assign jump_base = is_jalr ? rs1_val : pc;
    assign jump_pc   = jump_base + br_offset;
    assign fall_pc   = pc + 32'd4;

    // JALR clears bit 0 of the sum
    assign new_pc = branch_taken ? {jump_pc[31:1], jump_pc[0] & ~is_jalr} : fall_pc;

    // Bit 0 ignored when checking the prediction
    assign mispredict = (new_pc[31:1] != pred_pc[31:1]);
    // Taken target must be word aligned
    assign misaligned = branch_taken & new_pc[1] & misalign_en;

    ////////////////////
    // Result stage

    // Strobes pulse for one cycle per accepted issue
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            flush        <= 1'b0;
            exc_valid    <= 1'b0;
        end else begin
            result_valid <= accept;
            flush        <= accept & mispredict;
            exc_valid    <= accept & misaligned;
        end
    end

    // Payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            taken     <= branch_taken;
            target    <= new_pc;
            is_call   <= br_is_call;
            is_return <= br_is_return;
        end
    end

    // Faulting address is the resolved target itself
    assign exc_tval = target;

endmodule

`default_nettype wire

/* hw/branch_unit_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "branch_config.svh"

module branch_unit_top (
    input  logic                         clk,
    input  logic                         rst,
    // Issue
    input  logic                         issue_valid,
    input  logic [31:0]                  instr,
    input  logic [31:0]                  pc,
    input  logic [31:0]                  rs1_val,
    input  logic [31:0]                  rs2_val,
    input  logic [31:0]                  pred_pc,
    // Decode
    output logic                         unit_needed,
    output logic                         uses_rs1,
    output logic                         uses_rs2,
    // Results
    output logic                         result_valid,
    output logic                         taken,
    output logic [31:0]                  target,
    output logic                         flush,
    output logic                         is_call,
    output logic                         is_return,
    output logic                         exc_valid,
    output logic [31:0]                  exc_tval,
    // Wishbone
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`BR_WB_ADDR_WIDTH-1:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    input  logic [3:0]                   wb_sel,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack
);
    // Decode to resolver
    logic               accept;
    branch_pkg::br_op_t br_op;
    logic [31:0]        br_offset;
    logic               br_is_call;
    logic               br_is_return;
    // Control back to resolver
    logic               misalign_en;

    branch_decode u_decode (
        .instr, .issue_valid, .accept, .unit_needed, .uses_rs1, .uses_rs2,
        .br_op, .br_offset, .br_is_call, .br_is_return
    );

    branch_resolve u_resolve (
        .clk, .rst, .accept, .br_op, .br_offset, .br_is_call, .br_is_return,
        .pc, .rs1_val, .rs2_val, .pred_pc, .misalign_en,
        .result_valid, .taken, .target, .flush, .is_call, .is_return,
        .exc_valid, .exc_tval
    );

    branch_regs u_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
        .wb_dat_r, .wb_ack, .result_valid, .flush, .exc_valid, .exc_tval,
        .misalign_en
    );

endmodule

`default_nettype wire

/* tests/branch_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "branch_config.svh"

module branch_unit_tb;

    // DUT ports
    logic                         clk;
    logic                         rst;
    logic                         issue_valid;
    logic [31:0]                  instr;
    logic [31:0]                  pc;
    logic [31:0]                  rs1_val;
    logic [31:0]                  rs2_val;
    logic [31:0]                  pred_pc;
    logic                         unit_needed;
    logic                         uses_rs1;
    logic                         uses_rs2;
    logic                         result_valid;
    logic                         taken;
    logic [31:0]                  target;
    logic                         flush;
    logic                         is_call;
    logic                         is_return;
    logic                         exc_valid;
    logic [31:0]                  exc_tval;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [`BR_WB_ADDR_WIDTH-1:0] wb_adr;
    logic [31:0]                  wb_dat_w;
    logic [3:0]                   wb_sel;
    logic [31:0]                  wb_dat_r;
    logic                         wb_ack;

    // Model state
    // Entry layout {taken, target, flush, call, ret, exc}
    logic [36:0] exp_q[$];
    logic        misalign_on;
    logic [31:0] resolved_cnt;
    logic [31:0] flush_cnt;
    logic [31:0] last_tval;
    int          exc_seen;
    int          seed_dummy;

    branch_unit_top dut (
        .clk, .rst, .issue_valid, .instr, .pc, .rs1_val, .rs2_val, .pred_pc,
        .unit_needed, .uses_rs1, .uses_rs2, .result_valid, .taken, .target,
        .flush, .is_call, .is_return, .exc_valid, .exc_tval,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
    );

    always #2 clk = ~clk;

    ////////////////////
    // Checks

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_op(input string name, input branch_pkg::br_op_t exp,
                            input branch_pkg::br_op_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    ////////////////////
    // Reference model

    function automatic branch_pkg::br_op_t model_op(input logic [31:0] w);
        if (w[6:0] == 7'b1101111) begin
            return branch_pkg::BR_JAL;
        end
        // JALR defined only for fn3 zero
        if (w[6:0] == 7'b1100111 && w[14:12] == 3'b000) begin
            return branch_pkg::BR_JALR;
        end
        if (w[6:0] != 7'b1100011) begin
            return branch_pkg::BR_NONE;
        end
        case (w[14:12])
            3'd0:    return branch_pkg::BR_BEQ;
            3'd1:    return branch_pkg::BR_BNE;
            3'd4:    return branch_pkg::BR_BLT;
            3'd5:    return branch_pkg::BR_BGE;
            3'd6:    return branch_pkg::BR_BLTU;
            3'd7:    return branch_pkg::BR_BGEU;
            default: return branch_pkg::BR_NONE;
        endcase
    endfunction

    // Decode flags per op, {unit_needed, uses_rs1, uses_rs2}
    function automatic logic [2:0] op_flags(input branch_pkg::br_op_t op);
        case (op)
            branch_pkg::BR_NONE: return 3'b000;
            branch_pkg::BR_JAL:  return 3'b100;
            branch_pkg::BR_JALR: return 3'b110;
            default:             return 3'b111;
        endcase
    endfunction

    // B, J or I immediate
    function automatic logic [31:0] model_offset(input logic [31:0] w,
                                                 input branch_pkg::br_op_t op);
        if (op == branch_pkg::BR_JAL) begin
            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        if (op == branch_pkg::BR_JALR) begin
            return {{20{w[31]}}, w[31:20]};
        end
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic model_taken(input branch_pkg::br_op_t op, input logic [31:0] a,
                                         input logic [31:0] b);
        case (op)
            branch_pkg::BR_BEQ:  return a == b;
            branch_pkg::BR_BNE:  return a != b;
            branch_pkg::BR_BLT:  return $signed(a) < $signed(b);
            branch_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            branch_pkg::BR_BLTU: return a < b;
            branch_pkg::BR_BGEU: return a >= b;
            branch_pkg::BR_JAL:  return 1'b1;
            branch_pkg::BR_JALR: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    ////////////////////
    // Stimulus

    // Link registers and x0 come up often
    function automatic logic [4:0] pick_reg();
        case ($urandom % 4)
            0:       return 5'd0;
            1:       return 5'd1;
            2:       return 5'd5;
            default: return 5'($urandom);
        endcase
    endfunction

    // Equal, sign-boundary and small operands
    function automatic logic [31:0] pick_val();
        case ($urandom % 6)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            3:       return 32'hffff_ffff;
            4:       return $urandom % 8;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        int          kind;
        w = $urandom;
        kind = $urandom % 10;
        w[19:15] = pick_reg();
        w[11:7] = pick_reg();
        if (kind < 6) begin
            // fn3 000, 001, 100, 101, 110, 111
            w[6:0] = 7'b1100011;
            w[14:12] = 3'((kind < 2) ? kind : kind + 2);
        end else if (kind < 8) begin
            w[6:0] = 7'b1101111;
        end else if (kind == 8) begin
            w[6:0] = 7'b1100111;
            w[14:12] = 3'b000;
        end else begin
            w[6:0] = 7'($urandom);
            // Branch opcode with a reserved fn3
            if ($urandom % 3 == 0) begin
                w[6:0] = 7'b1100011;
                w[14:12] = {2'b01, w[12]};
            end
        end
        return w;
    endfunction

    // Result due this cycle, or nothing
    task automatic check_result();
        logic [36:0] exp;
        if (exp_q.size() == 0) begin
            check_bit("result_valid idle", 1'b0, result_valid);
            check_bit("flush idle", 1'b0, flush);
            check_bit("exc_valid idle", 1'b0, exc_valid);
        end else begin
            exp = exp_q.pop_front();
            check_bit("result_valid", 1'b1, result_valid);
            check_bit("taken", exp[36], taken);
            check_word("target", exp[35:4], target);
            check_bit("flush", exp[3], flush);
            check_bit("is_call", exp[2], is_call);
            check_bit("is_return", exp[1], is_return);
            check_bit("exc_valid", exp[0], exc_valid);
            if (exp[0]) begin
                check_word("exc_tval", exp[35:4], exc_tval);
            end
        end
    endtask

    // Back-to-back random issues, checked every cycle
    task automatic run_issues(input int count);
        logic [31:0]        w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        p;
        logic [31:0]        pred;
        logic [31:0]        t_pc;
        logic [31:0]        off;
        logic [2:0]         flags;
        logic               iv;
        logic               tk;
        logic               fl;
        logic               ex;
        logic               call;
        logic               ret;
        branch_pkg::br_op_t op;
        for (int i = 0; i < count; i++) begin
            w = make_instr();
            a = pick_val();
            b = ($urandom % 4 == 0) ? a : pick_val();
            p = $urandom;
            p[1:0] = 2'b00;
            iv = ($urandom % 8 != 0);
            op = model_op(w);
            off = model_offset(w, op);
            tk = model_taken(op, a, b);
            if (!tk) begin
                t_pc = p + 32'd4;
            end else if (op == branch_pkg::BR_JALR) begin
                t_pc = a + off;
                t_pc[0] = 1'b0;
            end else begin
                t_pc = p + off;
            end
            // Correct, bit-0 only, or wild prediction
            case ($urandom % 3)
                0:       pred = t_pc;
                1:       pred = t_pc ^ 32'd1;
                default: pred = $urandom;
            endcase
            fl = (t_pc[31:1] != pred[31:1]);
            ex = tk & t_pc[1] & misalign_on;
            call = (op == branch_pkg::BR_JAL || op == branch_pkg::BR_JALR) && is_link(w[11:7]);
            ret = (op == branch_pkg::BR_JALR) && is_link(w[19:15])
                  && (!is_link(w[11:7]) || w[11:7] != w[19:15]);
            @(posedge clk);
            issue_valid <= iv;
            instr <= w;
            pc <= p;
            rs1_val <= a;
            rs2_val <= b;
            pred_pc <= pred;
            @(negedge clk);
            // Decode is combinational on the current word
            flags = op_flags(op);
            check_op("decode op", op, dut.br_op);
            check_bit("unit_needed", flags[2], unit_needed);
            check_bit("uses_rs1", flags[1], uses_rs1);
            check_bit("uses_rs2", flags[0], uses_rs2);
            check_result();
            if (iv && op != branch_pkg::BR_NONE) begin
                exp_q.push_back({tk, t_pc, fl, call, ret, ex});
                resolved_cnt++;
                if (fl) begin
                    flush_cnt++;
                end
                if (ex) begin
                    last_tval = t_pc;
                    exc_seen++;
                end
            end
        end
        // Last result, then the counter update edge
        @(posedge clk);
        issue_valid <= 1'b0;
        @(negedge clk);
        check_result();
        @(posedge clk);
    endtask

    ////////////////////
    // Wishbone master

    task automatic wb_access(input logic we, input branch_pkg::br_reg_t r,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= {r, 2'b00};
        wb_dat_w <= wdata;
        wb_sel <= 4'hf;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (waited == 8) begin
                stop_with_failure("Wishbone bus did not answer with ack");
            end
            waited++;
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    ////////////////////
    // Main sequence

    initial begin : main
        logic [31:0] rd;
        seed_dummy = $urandom(32'h3e54);
        clk = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        instr = 32'd0;
        pc = 32'd0;
        rs1_val = 32'd0;
        rs2_val = 32'd0;
        pred_pc = 32'd0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = 32'd0;
        wb_sel = 4'h0;
        misalign_on = 1'b1;
        resolved_cnt = 32'd0;
        flush_cnt = 32'd0;
        last_tval = 32'd0;
        exc_seen = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Check enabled out of reset
        wb_access(1'b0, branch_pkg::REG_CTRL, 32'd0, rd);
        check_word("ctrl reset value", 32'd1, rd);
        run_issues(400);
        if (exc_seen == 0) begin
            stop_with_failure("no misaligned taken target was generated");
        end

        // Check off, exceptions must stay quiet
        wb_access(1'b1, branch_pkg::REG_CTRL, 32'd0, rd);
        misalign_on = 1'b0;
        wb_access(1'b0, branch_pkg::REG_CTRL, 32'd0, rd);
        check_word("ctrl readback", 32'd0, rd);
        run_issues(400);

        // Statistics against the model
        wb_access(1'b0, branch_pkg::REG_RESOLVED, 32'd0, rd);
        check_word("resolved count", resolved_cnt, rd);
        wb_access(1'b0, branch_pkg::REG_FLUSHES, 32'd0, rd);
        check_word("flush count", flush_cnt, rd);
        wb_access(1'b0, branch_pkg::REG_EXC_TVAL, 32'd0, rd);
        check_word("exc tval", last_tval, rd);

        // Read-only register ignores writes
        wb_access(1'b1, branch_pkg::REG_RESOLVED, 32'hdead_beef, rd);
        wb_access(1'b0, branch_pkg::REG_RESOLVED, 32'd0, rd);
        check_word("resolved after write", resolved_cnt, rd);

        $display("PASS: all tests");
        $finish;
    end

    // Overall limit on run time
    initial begin
        #200000;
        stop_with_failure("simulation ran past its time limit");
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/branch_pkg.sv
hw/branch_decode.sv
hw/branch_resolve.sv
hw/branch_regs.sv
hw/branch_unit_top.sv
tests/branch_unit_tb.sv
